// File: include/vdp_settings.svh
`ifndef VDP_SETTINGS_SVH
`define VDP_SETTINGS_SVH

// Datapath and address widths
`define VDP_DATA_W     64
`define VDP_ADDR_W     40
`define VDP_CSR_IDX_W  4

// Operand buffer depth and counter width (counts 0 to 8)
`define VDP_MAX_LEN    8
`define VDP_LEN_W      4

// Byte distance between consecutive vector elements
`define VDP_ELEM_BYTES 8

// CSR map
`define VDP_CSR_A_PTR   4'd0
`define VDP_CSR_B_PTR   4'd1
`define VDP_CSR_LEN     4'd2
`define VDP_CSR_START   4'd3
`define VDP_CSR_STATUS  4'd4
`define VDP_CSR_RES_PTR 4'd5

`endif

// File: rtl/vdp_pkg.sv
`include "vdp_settings.svh"

package vdp_pkg;

  // Single-beat CSR command
  typedef struct packed {
    logic                      write;
    logic [`VDP_CSR_IDX_W-1:0] idx;
    logic [`VDP_DATA_W-1:0]    data;
  } csr_cmd_t;

  // Response echoes the command's kind and index
  typedef struct packed {
    logic                      write;
    logic [`VDP_CSR_IDX_W-1:0] idx;
    logic [`VDP_DATA_W-1:0]    data;
  } csr_resp_t;

  // Run configuration seen by the sequencer
  typedef struct packed {
    logic [`VDP_ADDR_W-1:0] a_ptr;
    logic [`VDP_ADDR_W-1:0] b_ptr;
    logic [`VDP_ADDR_W-1:0] res_ptr;
    // Already saturated to 0..8
    logic [`VDP_LEN_W-1:0]  len;
  } vdp_cfg_t;

  // Memory request, load when write is low
  typedef struct packed {
    logic                   write;
    logic [`VDP_ADDR_W-1:0] addr;
    logic [`VDP_DATA_W-1:0] data;
  } mem_req_t;

endpackage

// File: rtl/vdp_csr_regs.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_csr_regs
  (input  logic               clk_i
  , input  logic               reset_i

  , input  vdp_pkg::csr_cmd_t  csr_cmd_i
  , input  logic               csr_cmd_v_i
  , output logic               csr_cmd_ready_o

  , output vdp_pkg::csr_resp_t csr_resp_o
  , output logic               csr_resp_v_o
  , input  logic               csr_resp_ready_i

  , input  logic               busy_i
  , input  logic               done_i
  , output vdp_pkg::vdp_cfg_t  cfg_o
  , output logic               start_pending_o
  );

  localparam logic [`VDP_LEN_W-1:0] max_len = `VDP_MAX_LEN;

  logic [`VDP_DATA_W-1:0] a_ptr_r;
  logic [`VDP_DATA_W-1:0] b_ptr_r;
  logic [`VDP_DATA_W-1:0] len_r;
  logic [`VDP_DATA_W-1:0] start_r;
  logic [`VDP_DATA_W-1:0] res_ptr_r;

  logic                   cmd_fire;
  logic [`VDP_DATA_W-1:0] rd_data;
  vdp_pkg::csr_resp_t     resp_r;
  logic                   resp_v_r;

  // Only one transaction in flight
  assign csr_cmd_ready_o = ~resp_v_r;
  assign cmd_fire        = csr_cmd_v_i & csr_cmd_ready_o;

  always_comb begin
    case (csr_cmd_i.idx)
      `VDP_CSR_A_PTR:   rd_data = a_ptr_r;
      `VDP_CSR_B_PTR:   rd_data = b_ptr_r;
      `VDP_CSR_LEN:     rd_data = len_r;
      `VDP_CSR_START:   rd_data = start_r;
      `VDP_CSR_STATUS:  rd_data = {{(`VDP_DATA_W-1){1'b0}}, ~busy_i};
      `VDP_CSR_RES_PTR: rd_data = res_ptr_r;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      len_r     <= '0;
      start_r   <= '0;
      res_ptr_r <= '0;
    end else begin
      if (done_i)
        start_r <= '0;
      // A write landing on the done cycle still wins
      if (cmd_fire && csr_cmd_i.write) begin
        case (csr_cmd_i.idx)
          `VDP_CSR_A_PTR:   a_ptr_r   <= csr_cmd_i.data;
          `VDP_CSR_B_PTR:   b_ptr_r   <= csr_cmd_i.data;
          `VDP_CSR_LEN:     len_r     <= csr_cmd_i.data;
          `VDP_CSR_START:   start_r   <= csr_cmd_i.data;
          `VDP_CSR_RES_PTR: res_ptr_r <= csr_cmd_i.data;
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (csr_resp_ready_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_r.write <= csr_cmd_i.write;
      resp_r.idx   <= csr_cmd_i.idx;
      resp_r.data  <= csr_cmd_i.write ? '0 : rd_data;
    end
  end

  assign csr_resp_o   = resp_r;
  assign csr_resp_v_o = resp_v_r;

  assign cfg_o.a_ptr   = a_ptr_r[`VDP_ADDR_W-1:0];
  assign cfg_o.b_ptr   = b_ptr_r[`VDP_ADDR_W-1:0];
  assign cfg_o.res_ptr = res_ptr_r[`VDP_ADDR_W-1:0];
  // Lengths above the buffer depth behave as a full buffer
  assign cfg_o.len     = (len_r > `VDP_MAX_LEN) ? max_len : len_r[`VDP_LEN_W-1:0];

  assign start_pending_o = (start_r != '0);

endmodule

// File: rtl/vdp_seq.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_seq
  (input  logic                   clk_i
  , input  logic                   reset_i

  , input  vdp_pkg::vdp_cfg_t      cfg_i
  , input  logic                   start_pending_i
  , output logic                   busy_o
  , output logic                   done_o

  , output vdp_pkg::mem_req_t      mem_req_o
  , output logic                   mem_req_v_o
  , input  logic                   mem_req_ready_i
  , input  logic                   mem_resp_v_i

  , output logic                   clear_bufs_o
  , output logic                   load_a_o
  , output logic                   load_b_o
  , input  logic [`VDP_LEN_W-1:0]  count_a_i
  , input  logic [`VDP_LEN_W-1:0]  count_b_i

  , output logic                   capture_o
  , input  logic [`VDP_DATA_W-1:0] result_i
  );

  typedef enum logic [2:0] {
    e_idle
    , e_issue
    , e_wait_resp
    , e_capture
    , e_store
    , e_wait_store
  } state_e;

  state_e                 state_r;
  state_e                 state_n;
  logic                   phase_b;
  logic                   last_b;
  logic [`VDP_ADDR_W-1:0] load_addr;

  // A is complete once its count reaches the length
  assign phase_b = (count_a_i == cfg_i.len);
  assign last_b  = phase_b && ((count_b_i + 1'b1) == cfg_i.len);

  assign load_addr = phase_b ? (cfg_i.b_ptr + count_b_i * `VDP_ELEM_BYTES)
                             : (cfg_i.a_ptr + count_a_i * `VDP_ELEM_BYTES);

  always_ff @(posedge clk_i) begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_comb begin
    state_n         = state_r;
    mem_req_v_o     = 1'b0;
    mem_req_o.write = 1'b0;
    mem_req_o.addr  = load_addr;
    mem_req_o.data  = '0;
    clear_bufs_o    = 1'b0;
    load_a_o        = 1'b0;
    load_b_o        = 1'b0;
    capture_o       = 1'b0;
    done_o          = 1'b0;

    case (state_r)
      e_idle: begin
        if (start_pending_i) begin
          clear_bufs_o = 1'b1;
          // Empty vectors skip straight to a zero result
          state_n      = (cfg_i.len == '0) ? e_capture : e_issue;
        end
      end
      e_issue: begin
        mem_req_v_o = 1'b1;
        if (mem_req_ready_i)
          state_n = e_wait_resp;
      end
      e_wait_resp: begin
        if (mem_resp_v_i) begin
          load_a_o = ~phase_b;
          load_b_o = phase_b;
          state_n  = last_b ? e_capture : e_issue;
        end
      end
      e_capture: begin
        capture_o = 1'b1;
        state_n   = e_store;
      end
      e_store: begin
        mem_req_v_o     = 1'b1;
        mem_req_o.write = 1'b1;
        mem_req_o.addr  = cfg_i.res_ptr;
        mem_req_o.data  = result_i;
        if (mem_req_ready_i)
          state_n = e_wait_store;
      end
      e_wait_store: begin
        if (mem_resp_v_i) begin
          done_o  = 1'b1;
          state_n = e_idle;
        end
      end
      default: begin
        state_n = e_idle;
      end
    endcase
  end

  assign busy_o = (state_r != e_idle);

endmodule

// File: rtl/vdp_operand_buf.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_operand_buf
  (input  logic                                     clk_i
  , input  logic                                     reset_i
  , input  logic                                     clear_i
  , input  logic                                     load_a_i
  , input  logic                                     load_b_i
  , input  logic [`VDP_DATA_W-1:0]                   data_i
  , output logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_a_o
  , output logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_b_o
  , output logic [`VDP_LEN_W-1:0]                    count_a_o
  , output logic [`VDP_LEN_W-1:0]                    count_b_o
  );

  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_a_r;
  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_b_r;
  logic [`VDP_LEN_W-1:0]                    count_a_r;
  logic [`VDP_LEN_W-1:0]                    count_b_r;

  // Cleared entries multiply to 0 in the tree
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      vec_a_r <= '0;
      vec_b_r <= '0;
    end else begin
      if (load_a_i)
        vec_a_r[count_a_r[`VDP_LEN_W-2:0]] <= data_i;
      if (load_b_i)
        vec_b_r[count_b_r[`VDP_LEN_W-2:0]] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      count_a_r <= '0;
      count_b_r <= '0;
    end else begin
      if (load_a_i)
        count_a_r <= count_a_r + 1'b1;
      if (load_b_i)
        count_b_r <= count_b_r + 1'b1;
    end
  end

  assign vec_a_o   = vec_a_r;
  assign vec_b_o   = vec_b_r;
  assign count_a_o = count_a_r;
  assign count_b_o = count_b_r;

endmodule

// File: rtl/vdp_dot_tree.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_dot_tree
  (input  logic                                     clk_i
  , input  logic                                     reset_i
  , input  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_a_i
  , input  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_b_i
  , input  logic                                     capture_i
  , output logic [`VDP_DATA_W-1:0]                   result_o
  );

  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0]   prod;
  logic [`VDP_MAX_LEN/2-1:0][`VDP_DATA_W-1:0] sum_l1;
  logic [`VDP_MAX_LEN/4-1:0][`VDP_DATA_W-1:0] sum_l2;
  logic [`VDP_DATA_W-1:0]                     sum_l3;
  logic [`VDP_DATA_W-1:0]                     result_r;

  // Products keep the low 64 bits only
  for (genvar i = 0; i < `VDP_MAX_LEN; i++) begin : g_mul
    assign prod[i] = vec_a_i[i] * vec_b_i[i];
  end

  for (genvar i = 0; i < `VDP_MAX_LEN/2; i++) begin : g_l1
    assign sum_l1[i] = prod[2*i] + prod[2*i+1];
  end

  for (genvar i = 0; i < `VDP_MAX_LEN/4; i++) begin : g_l2
    assign sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
  end

  assign sum_l3 = sum_l2[0] + sum_l2[1];

  // Held for the store request
  always_ff @(posedge clk_i) begin
    if (reset_i)
      result_r <= '0;
    else if (capture_i)
      result_r <= sum_l3;
  end

  assign result_o = result_r;

endmodule

// File: rtl/vdp_accel_top.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_accel_top
  (input  logic                   clk_i
  , input  logic                   reset_i

  , input  vdp_pkg::csr_cmd_t      csr_cmd_i
  , input  logic                   csr_cmd_v_i
  , output logic                   csr_cmd_ready_o
  , output vdp_pkg::csr_resp_t     csr_resp_o
  , output logic                   csr_resp_v_o
  , input  logic                   csr_resp_ready_i

  , output vdp_pkg::mem_req_t      mem_req_o
  , output logic                   mem_req_v_o
  , input  logic                   mem_req_ready_i
  , input  logic                   mem_resp_v_i
  , input  logic [`VDP_DATA_W-1:0] mem_resp_data_i
  );

  vdp_pkg::vdp_cfg_t                        cfg;
  logic                                     start_pending;
  logic                                     busy;
  logic                                     done;
  logic                                     clear_bufs;
  logic                                     load_a;
  logic                                     load_b;
  logic                                     capture;
  logic [`VDP_LEN_W-1:0]                    count_a;
  logic [`VDP_LEN_W-1:0]                    count_b;
  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_a;
  logic [`VDP_MAX_LEN-1:0][`VDP_DATA_W-1:0] vec_b;
  logic [`VDP_DATA_W-1:0]                   result;

  vdp_csr_regs csr_regs
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.csr_cmd_i(csr_cmd_i)
    ,.csr_cmd_v_i(csr_cmd_v_i)
    ,.csr_cmd_ready_o(csr_cmd_ready_o)
    ,.csr_resp_o(csr_resp_o)
    ,.csr_resp_v_o(csr_resp_v_o)
    ,.csr_resp_ready_i(csr_resp_ready_i)
    ,.busy_i(busy)
    ,.done_i(done)
    ,.cfg_o(cfg)
    ,.start_pending_o(start_pending)
    );

  vdp_seq seq
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.cfg_i(cfg)
    ,.start_pending_i(start_pending)
    ,.busy_o(busy)
    ,.done_o(done)
    ,.mem_req_o(mem_req_o)
    ,.mem_req_v_o(mem_req_v_o)
    ,.mem_req_ready_i(mem_req_ready_i)
    ,.mem_resp_v_i(mem_resp_v_i)
    ,.clear_bufs_o(clear_bufs)
    ,.load_a_o(load_a)
    ,.load_b_o(load_b)
    ,.count_a_i(count_a)
    ,.count_b_i(count_b)
    ,.capture_o(capture)
    ,.result_i(result)
    );

  // Load data comes straight from the memory response
  vdp_operand_buf bufs
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.clear_i(clear_bufs)
    ,.load_a_i(load_a)
    ,.load_b_i(load_b)
    ,.data_i(mem_resp_data_i)
    ,.vec_a_o(vec_a)
    ,.vec_b_o(vec_b)
    ,.count_a_o(count_a)
    ,.count_b_o(count_b)
    );

  vdp_dot_tree tree
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.vec_a_i(vec_a)
    ,.vec_b_i(vec_b)
    ,.capture_i(capture)
    ,.result_o(result)
    );

endmodule

// File: testbench/vdp_mem_stub.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_mem_stub
  #(parameter int unsigned seed_init = 32'h0594988e)
  (input  logic                   clk_i
  , input  logic                   reset_i
  , input  vdp_pkg::mem_req_t      mem_req_i
  , input  logic                   mem_req_v_i
  , output logic                   mem_req_ready_o
  , output logic                   mem_resp_v_o
  , output logic [`VDP_DATA_W-1:0] mem_resp_data_o
  );

  // Sparse image, filled on first load of an address
  logic [`VDP_DATA_W-1:0] image [logic [`VDP_ADDR_W-1:0]];
  vdp_pkg::mem_req_t      req_log [$];
  integer                 seed;
  logic                   pending;
  int                     wait_cnt;
  logic [`VDP_DATA_W-1:0] pend_data;

  initial begin
    seed            = seed_init;
    mem_req_ready_o = 1'b0;
    mem_resp_v_o    = 1'b0;
    mem_resp_data_o = '0;
    pending         = 1'b0;
    wait_cnt        = 0;
    pend_data       = '0;
  end

  // Ready set here is what the next rising edge samples
  always @(negedge clk_i) begin
    mem_resp_v_o = 1'b0;
    if (reset_i) begin
      mem_req_ready_o = 1'b0;
      pending         = 1'b0;
    end else if (pending) begin
      mem_req_ready_o = 1'b0;
      if (wait_cnt == 0) begin
        mem_resp_v_o    = 1'b1;
        mem_resp_data_o = pend_data;
        pending         = 1'b0;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end else begin
      // Ready three times out of four
      mem_req_ready_o = (($random(seed) & 3) != 0);
      if (mem_req_ready_o && mem_req_v_i) begin
        req_log.push_back(mem_req_i);
        if (!mem_req_i.write && !image.exists(mem_req_i.addr))
          image[mem_req_i.addr] = {$random(seed), $random(seed)};
        pend_data = mem_req_i.write ? '0 : image[mem_req_i.addr];
        pending   = 1'b1;
        // 1 to 4 cycles until the response
        wait_cnt  = $unsigned($random(seed)) % 4;
      end
    end
  end

endmodule

// File: testbench/vdp_tb.sv
`timescale 1ns/1ps
`include "vdp_settings.svh"

module vdp_tb;

  localparam int num_runs   = 22;
  localparam int run_cycles = `VDP_MAX_LEN * 2 * 6 + 40;

  logic                   clk_i;
  logic                   reset_i;
  vdp_pkg::csr_cmd_t      csr_cmd;
  logic                   csr_cmd_v;
  logic                   csr_cmd_ready;
  vdp_pkg::csr_resp_t     csr_resp;
  logic                   csr_resp_v;
  logic                   csr_resp_ready;
  vdp_pkg::mem_req_t      mem_req;
  logic                   mem_req_v;
  logic                   mem_req_ready;
  logic                   mem_resp_v;
  logic [`VDP_DATA_W-1:0] mem_resp_data;
  integer                 seed;
  logic [3:0]             idx;
  logic [63:0]            data;

  vdp_accel_top uut
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.csr_cmd_i(csr_cmd)
    ,.csr_cmd_v_i(csr_cmd_v)
    ,.csr_cmd_ready_o(csr_cmd_ready)
    ,.csr_resp_o(csr_resp)
    ,.csr_resp_v_o(csr_resp_v)
    ,.csr_resp_ready_i(csr_resp_ready)
    ,.mem_req_o(mem_req)
    ,.mem_req_v_o(mem_req_v)
    ,.mem_req_ready_i(mem_req_ready)
    ,.mem_resp_v_i(mem_resp_v)
    ,.mem_resp_data_i(mem_resp_data)
    );

  vdp_mem_stub #(.seed_init(32'h0594988e)) mem
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.mem_req_i(mem_req)
    ,.mem_req_v_i(mem_req_v)
    ,.mem_req_ready_o(mem_req_ready)
    ,.mem_resp_v_o(mem_resp_v)
    ,.mem_resp_data_o(mem_resp_data)
    );

  always #5 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic bit coin();
    return ($random(seed) & 1) != 0;
  endfunction

  function automatic logic [39:0] rand_ptr();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return {r[39:3], 3'b000};
  endfunction

  function automatic logic [39:0] elem_addr(input logic [39:0] base, input int i);
    return base + i * `VDP_ELEM_BYTES;
  endfunction

  // Entered and left on a falling edge
  task automatic csr_transfer(input logic wr, input logic [3:0] index,
                              input logic [63:0] wdata, input bit bp,
                              output logic [63:0] rd);
    csr_cmd.write = wr;
    csr_cmd.idx   = index;
    csr_cmd.data  = wdata;
    csr_cmd_v     = 1'b1;
    assert (csr_cmd_ready)
      else report_failure("CSR command port was not ready with no response pending");
    @(negedge clk_i);
    csr_cmd_v = 1'b0;
    assert (csr_resp_v)
      else report_failure("CSR response did not arrive one cycle after the command");
    assert (!csr_cmd_ready)
      else report_failure($sformatf("** Error: csr_cmd_ready_o = 0x%h, expected 0x0",
                                    csr_cmd_ready));
    csr_resp_ready = bp ? coin() : 1'b1;
    while (!csr_resp_ready) begin
      @(negedge clk_i);
      csr_resp_ready = coin();
    end
    assert (csr_resp_v && csr_resp.idx == index)
      else report_failure($sformatf("** Error: csr_resp_o.idx = 0x%h, expected 0x%h",
                                    csr_resp.idx, index));
    assert (csr_resp.write == wr)
      else report_failure($sformatf("** Error: csr_resp_o.write = 0x%h, expected 0x%h",
                                    csr_resp.write, wr));
    rd = csr_resp.data;
    @(negedge clk_i);
    csr_resp_ready = 1'b0;
  endtask

  task automatic csr_write(input logic [3:0] index, input logic [63:0] wdata, input bit bp);
    logic [63:0] rd;
    csr_transfer(1'b1, index, wdata, bp, rd);
    assert (rd == 64'd0)
      else report_failure($sformatf("** Error: csr_resp_o.data on write = 0x%h, expected 0x0",
                                    rd));
  endtask

  task automatic expect_read(input logic [3:0] index, input logic [63:0] expected,
                             input bit bp);
    logic [63:0] rd;
    csr_transfer(1'b0, index, 64'd0, bp, rd);
    assert (rd == expected)
      else report_failure($sformatf("** Error: csr_resp_o.data (CSR 0x%h) = 0x%h, expected 0x%h",
                                    index, rd, expected));
  endtask

  task automatic run_dot(input logic [39:0] a_ptr, input logic [39:0] b_ptr,
                         input logic [39:0] res_ptr, input logic [63:0] len);
    int                n;
    int                base;
    int                i;
    logic [63:0]       status;
    logic [63:0]       expected;
    logic [39:0]       exp_addr;
    vdp_pkg::mem_req_t req;
    n    = (len > `VDP_MAX_LEN) ? `VDP_MAX_LEN : int'(len);
    base = mem.req_log.size();
    csr_write(`VDP_CSR_A_PTR, {24'd0, a_ptr}, coin());
    csr_write(`VDP_CSR_B_PTR, {24'd0, b_ptr}, coin());
    csr_write(`VDP_CSR_RES_PTR, {24'd0, res_ptr}, coin());
    csr_write(`VDP_CSR_LEN, len, coin());
    csr_write(`VDP_CSR_START, 64'd1, 1'b0);
    // Engine has already left idle and cannot have stored yet
    expect_read(`VDP_CSR_STATUS, 64'd0, 1'b0);
    csr_transfer(1'b0, `VDP_CSR_STATUS, 64'd0, 1'b1, status);
    while (status == 64'd0)
      csr_transfer(1'b0, `VDP_CSR_STATUS, 64'd0, 1'b1, status);
    assert (status == 64'd1)
      else report_failure($sformatf("** Error: csr_resp_o.data (status) = 0x%h, expected 0x1",
                                    status));
    expect_read(`VDP_CSR_START, 64'd0, 1'b1);

    expected = 64'd0;
    for (i = 0; i < n; i++)
      expected = expected + mem.image[elem_addr(a_ptr, i)] * mem.image[elem_addr(b_ptr, i)];

    assert (mem.req_log.size() == base + 2 * n + 1)
      else report_failure($sformatf("** Error: memory request count = 0x%h, expected 0x%h",
                                    mem.req_log.size() - base, 2 * n + 1));
    for (i = 0; i < 2 * n + 1; i++) begin
      req = mem.req_log[base + i];
      if (i < n)
        exp_addr = elem_addr(a_ptr, i);
      else if (i < 2 * n)
        exp_addr = elem_addr(b_ptr, i - n);
      else
        exp_addr = res_ptr;
      assert (req.addr == exp_addr && req.write == (i == 2 * n))
        else report_failure($sformatf(
          "** Error: mem_req_o.addr/write (request %0d) = 0x%h/0x%h, expected 0x%h/0x%h",
          i, req.addr, req.write, exp_addr, i == 2 * n));
    end
    req = mem.req_log[base + 2 * n];
    assert (req.data == expected)
      else report_failure($sformatf("** Error: mem_req_o.data (store) = 0x%h, expected 0x%h",
                                    req.data, expected));
  endtask

  initial begin
    seed           = 32'h0594988e;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    csr_cmd        = '0;
    csr_cmd_v      = 1'b0;
    csr_resp_ready = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i <= 1'b0;

    // Reset values and an unmapped index
    expect_read(`VDP_CSR_STATUS, 64'd1, 1'b0);
    expect_read(`VDP_CSR_A_PTR, 64'd0, 1'b0);
    expect_read(`VDP_CSR_B_PTR, 64'd0, 1'b0);
    expect_read(`VDP_CSR_LEN, 64'd0, 1'b0);
    expect_read(`VDP_CSR_START, 64'd0, 1'b0);
    expect_read(`VDP_CSR_RES_PTR, 64'd0, 1'b0);
    expect_read(4'd9, 64'd0, 1'b0);

    repeat (12) begin
      case ($random(seed) & 3)
        0: idx = `VDP_CSR_A_PTR;
        1: idx = `VDP_CSR_B_PTR;
        2: idx = `VDP_CSR_LEN;
        default: idx = `VDP_CSR_RES_PTR;
      endcase
      data = {$random(seed), $random(seed)};
      csr_write(idx, data, 1'b1);
      expect_read(idx, data, 1'b1);
    end

    repeat (num_runs - 2)
      run_dot(rand_ptr(), rand_ptr(), rand_ptr(), 64'd1 + ($random(seed) & 7));
    run_dot(rand_ptr(), rand_ptr(), rand_ptr(), 64'd0);
    run_dot(rand_ptr(), rand_ptr(), rand_ptr(), 64'd12);

    $display("TEST OK");
    $finish;
  end

  initial begin
    #(num_runs * run_cycles * 10);
    $display("Timeout: the run did not finish within %0d ns", num_runs * run_cycles * 10);
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

// File: vdp_accel.f
+incdir+include
rtl/vdp_pkg.sv
rtl/vdp_csr_regs.sv
rtl/vdp_seq.sv
rtl/vdp_operand_buf.sv
rtl/vdp_dot_tree.sv
rtl/vdp_accel_top.sv
testbench/vdp_mem_stub.sv
testbench/vdp_tb.sv

// File: Makefile
# Verilator build and run for the vector dot-product accelerator

VERILATOR  ?= verilator
FILELIST   ?= vdp_accel.f
TOP        ?= vdp_tb
RTL_TOP    ?= vdp_accel_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SOURCES := $(wildcard include/*.svh rtl/*.sv testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The simulator's exit status carries pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
